// ==== source/md_pair_pkg.sv ====
// Pair distance shared types
package md_pair_pkg;

	// Coordinate format is signed Q8.8
	localparam int COORD_W    = 16;
	localparam int COORD_FRAC = 8;

	// One extra bit so neighbor minus reference never overflows
	localparam int DELTA_W = COORD_W + 1;

	// Squares carry twice the fraction bits
	localparam int R2_FRAC = 2 * COORD_FRAC;

	// Three squared 17-bit deltas fit below 2**34 with headroom
	localparam int R2_W = 36;

	localparam int PAIR_ID_W = 8;
	localparam int COUNT_W   = 16;

	// Scalar types
	typedef logic signed [COORD_W-1:0] coord_t;
	typedef logic signed [DELTA_W-1:0] delta_t;
	typedef logic [R2_W-1:0]           r2_t;
	typedef logic [PAIR_ID_W-1:0]      pair_id_t;
	typedef logic [COUNT_W-1:0]        pair_count_t;

	// Particle position
	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t z;
	} pos_t;

	// Reference and neighbor with their sequence tag
	typedef struct packed {
		pos_t     ref_pos;
		pos_t     nbr_pos;
		pair_id_t id;
	} pair_t;

	// Displacement as neighbor minus reference
	typedef struct packed {
		delta_t dx;
		delta_t dy;
		delta_t dz;
	} disp_t;

	// Pipeline result with deltas kept for the force stage
	typedef struct packed {
		pair_id_t id;
		disp_t    disp;
		r2_t      r2;
	} r2_result_t;

	// Cutoff of 12.0 squared in Q18.16
	localparam r2_t CUTOFF_R2 = r2_t'(144) << R2_FRAC;

	// Cycle counts per stage
	localparam int SAMPLER_LATENCY = 1;
	localparam int R2_LATENCY      = 3;
	localparam int FILTER_LATENCY  = 1;
	localparam int TOP_LATENCY     = SAMPLER_LATENCY + R2_LATENCY + FILTER_LATENCY;

endpackage

// ==== source/pair_sampler.sv ====
// Position pair sampler
`timescale 1ns/1ps

module pair_sampler (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               enable,
	input  md_pair_pkg::pos_t  ref_pos,
	input  md_pair_pkg::pos_t  nbr_pos,
	output logic               pair_valid,
	output md_pair_pkg::pair_t pair
);

	// Id given to the next sampled pair
	md_pair_pkg::pair_id_t next_id;

	// Control state
	// Valid follows enable by one cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pair_valid <= 1'b0;
			next_id    <= '0;
		end else begin
			pair_valid <= enable;
			// Id only moves on a sampled pair and wraps at 255
			if (enable) begin
				next_id <= next_id + 1'b1;
			end
		end
	end

	// Payload capture
	// Held between samples so the pair stays stable while idle
	always_ff @(posedge clk) begin
		if (enable) begin
			pair.ref_pos <= ref_pos;
			pair.nbr_pos <= nbr_pos;
			pair.id      <= next_id;
		end
	end

endmodule

// ==== source/r2_compute.sv ====
// Squared distance pipeline
`timescale 1ns/1ps

module r2_compute (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    pair_valid,
	input  md_pair_pkg::pair_t      pair,
	output logic                    r2_valid,
	output md_pair_pkg::r2_result_t result
);

	// Neighbor minus reference with sign extension to delta width
	function automatic md_pair_pkg::delta_t diff(
		input md_pair_pkg::coord_t nbr_c,
		input md_pair_pkg::coord_t ref_c
	);
		return md_pair_pkg::delta_t'(nbr_c) - md_pair_pkg::delta_t'(ref_c);
	endfunction

	// Exact square of one delta
	function automatic md_pair_pkg::r2_t square(input md_pair_pkg::delta_t d);
		logic signed [2*md_pair_pkg::DELTA_W-1:0] prod;
		prod = d * d;
		// Product is never negative so zero extension is safe
		return md_pair_pkg::r2_t'(unsigned'(prod));
	endfunction

	// One valid bit per level
	logic [md_pair_pkg::R2_LATENCY-1:0] valid_sr;

	// Level 1 registers
	md_pair_pkg::disp_t    l1_disp;
	md_pair_pkg::pair_id_t l1_id;

	// Level 2 registers
	md_pair_pkg::r2_t      l2_sq_x;
	md_pair_pkg::r2_t      l2_sq_y;
	md_pair_pkg::r2_t      l2_sq_z;
	md_pair_pkg::disp_t    l2_disp;
	md_pair_pkg::pair_id_t l2_id;

	// Valid shift register
	// Bit 0 marks level 1 and the top bit marks the result
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_sr <= '0;
		end else begin
			valid_sr <= {valid_sr[md_pair_pkg::R2_LATENCY-2:0], pair_valid};
		end
	end

	assign r2_valid = valid_sr[md_pair_pkg::R2_LATENCY-1];

	// Level 1 subtracts reference from neighbor
	always_ff @(posedge clk) begin
		if (pair_valid) begin
			l1_disp.dx <= diff(pair.nbr_pos.x, pair.ref_pos.x);
			l1_disp.dy <= diff(pair.nbr_pos.y, pair.ref_pos.y);
			l1_disp.dz <= diff(pair.nbr_pos.z, pair.ref_pos.z);
			l1_id      <= pair.id;
		end
	end

	// Level 2 squares each component
	// Deltas and id ride along for the result
	always_ff @(posedge clk) begin
		if (valid_sr[0]) begin
			l2_sq_x <= square(l1_disp.dx);
			l2_sq_y <= square(l1_disp.dy);
			l2_sq_z <= square(l1_disp.dz);
			l2_disp <= l1_disp;
			l2_id   <= l1_id;
		end
	end

	// Level 3 sums the squares
	// Sum stays below 2**34 so no carry is lost
	always_ff @(posedge clk) begin
		if (valid_sr[1]) begin
			result.r2   <= l2_sq_x + l2_sq_y + l2_sq_z;
			result.disp <= l2_disp;
			result.id   <= l2_id;
		end
	end

endmodule

// ==== source/cutoff_filter.sv ====
// Cutoff radius filter
`timescale 1ns/1ps

module cutoff_filter (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     r2_valid,
	input  md_pair_pkg::r2_result_t  result,
	output logic                     out_valid,
	output md_pair_pkg::r2_result_t  out_pair,
	output md_pair_pkg::pair_count_t accepted_count,
	output md_pair_pkg::pair_count_t rejected_count
);

	// Strictly below the cutoff counts as in range
	logic in_range;

	assign in_range = result.r2 < md_pair_pkg::CUTOFF_R2;

	// Output strobe and tallies
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid      <= 1'b0;
			accepted_count <= '0;
			rejected_count <= '0;
		end else begin
			// Pulse only for an in-range pair
			out_valid <= r2_valid && in_range;
			// Exactly one counter moves per result
			if (r2_valid) begin
				if (in_range) begin
					accepted_count <= accepted_count + 1'b1;
				end else begin
					rejected_count <= rejected_count + 1'b1;
				end
			end
		end
	end

	// Accepted result capture
	// Rejected pairs leave the last accepted one on the port
	always_ff @(posedge clk) begin
		if (r2_valid && in_range) begin
			out_pair <= result;
		end
	end

endmodule

// ==== source/pair_distance_top.sv ====
// Pair distance range limit
`timescale 1ns/1ps

module pair_distance_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     enable,
	input  md_pair_pkg::pos_t        ref_pos,
	input  md_pair_pkg::pos_t        nbr_pos,
	output logic                     out_valid,
	output md_pair_pkg::r2_result_t  out_pair,
	output md_pair_pkg::pair_count_t accepted_count,
	output md_pair_pkg::pair_count_t rejected_count
);

	// Sampler to pipeline
	logic               pair_valid;
	md_pair_pkg::pair_t pair;

	// Pipeline to filter
	logic                    r2_valid;
	md_pair_pkg::r2_result_t result;

	// Registers enabled pairs and tags them
	pair_sampler sampler_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.enable     (enable),
		.ref_pos    (ref_pos),
		.nbr_pos    (nbr_pos),
		.pair_valid (pair_valid),
		.pair       (pair)
	);

	// Three cycles of subtract, square and sum
	r2_compute r2_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.pair_valid (pair_valid),
		.pair       (pair),
		.r2_valid   (r2_valid),
		.result     (result)
	);

	// Drops pairs at or beyond the cutoff
	cutoff_filter filter_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.r2_valid       (r2_valid),
		.result         (result),
		.out_valid      (out_valid),
		.out_pair       (out_pair),
		.accepted_count (accepted_count),
		.rejected_count (rejected_count)
	);

endmodule

// ==== testbench/pair_distance_properties.sv ====
// Pair distance assertions
`timescale 1ns/1ps

module pair_distance_properties (
	input logic                     clk,
	input logic                     rst_n,
	input logic                     enable,
	input md_pair_pkg::pos_t        ref_pos,
	input md_pair_pkg::pos_t        nbr_pos,
	input logic                     out_valid,
	input md_pair_pkg::r2_result_t  out_pair,
	input md_pair_pkg::pair_count_t accepted_count,
	input md_pair_pkg::pair_count_t rejected_count
);

	// Sum of squared deltas in 64-bit arithmetic
	function automatic md_pair_pkg::r2_t sum_sq(input md_pair_pkg::disp_t d);
		longint s;
		s = longint'(d.dx) * longint'(d.dx) + longint'(d.dy) * longint'(d.dy)
			+ longint'(d.dz) * longint'(d.dz);
		return md_pair_pkg::r2_t'(s);
	endfunction

	// Displacement of the pair on the input ports
	// Plain integer difference, then trimmed to the delta width
	md_pair_pkg::disp_t in_disp;
	logic               in_range;

	assign in_disp.dx = md_pair_pkg::delta_t'(int'(nbr_pos.x) - int'(ref_pos.x));
	assign in_disp.dy = md_pair_pkg::delta_t'(int'(nbr_pos.y) - int'(ref_pos.y));
	assign in_disp.dz = md_pair_pkg::delta_t'(int'(nbr_pos.z) - int'(ref_pos.z));
	assign in_range   = sum_sq(in_disp) < md_pair_pkg::CUTOFF_R2;

	out_quiet_after_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
		else $error("out_valid high right after reset");

	counters_clear_after_reset: assert property (@(posedge clk)
		!rst_n |=> (accepted_count == '0 && rejected_count == '0))
		else $error("counters not cleared by reset");

	// Every emitted pair is exact and inside the cutoff
	out_r2_exact: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (out_pair.r2 == sum_sq(out_pair.disp)
			&& out_pair.r2 < md_pair_pkg::CUTOFF_R2))
		else $error("emitted r2 wrong or beyond cutoff");

	// In-range input shows up after the fixed latency
	in_range_latency: assert property (@(posedge clk) disable iff (!rst_n)
		(enable && in_range) |-> ##(md_pair_pkg::TOP_LATENCY)
			(out_valid && out_pair.disp == $past(in_disp, md_pair_pkg::TOP_LATENCY)))
		else $error("in-range pair missing at fixed latency");

endmodule

bind pair_distance_top pair_distance_properties props_i (
	.clk            (clk),
	.rst_n          (rst_n),
	.enable         (enable),
	.ref_pos        (ref_pos),
	.nbr_pos        (nbr_pos),
	.out_valid      (out_valid),
	.out_pair       (out_pair),
	.accepted_count (accepted_count),
	.rejected_count (rejected_count)
);

// ==== testbench/pair_distance_tb.sv ====
// Pair distance testbench
`timescale 1ns/1ps

module pair_distance_tb;

	// Stimulus lengths in cycles
	localparam int RESET_CYCLES   = 5;
	localparam int RESET_TEST_LEN = 10;
	localparam int DIRECTED_LEN   = 4;
	localparam int BURST_LEN      = 200;
	localparam int BOUNDARY_LEN   = 4;
	localparam int GAPPED_LEN     = 150;
	localparam int DRAIN_CYCLES   = md_pair_pkg::TOP_LATENCY + 2;
	localparam int TOTAL_CYCLES   = RESET_CYCLES + RESET_TEST_LEN + DIRECTED_LEN + BURST_LEN
		+ BOUNDARY_LEN + GAPPED_LEN + 5 * DRAIN_CYCLES;
	localparam int CYCLE_LIMIT    = TOTAL_CYCLES + md_pair_pkg::TOP_LATENCY + 50;

	// One unit in Q8.8
	localparam int ONE = 256;

	logic                     clk;
	logic                     rst_n;
	logic                     enable;
	md_pair_pkg::pos_t        ref_pos;
	md_pair_pkg::pos_t        nbr_pos;
	logic                     out_valid;
	md_pair_pkg::r2_result_t  out_pair;
	md_pair_pkg::pair_count_t accepted_count;
	md_pair_pkg::pair_count_t rejected_count;

	// Reference model state
	md_pair_pkg::r2_result_t  expected_q[$];
	md_pair_pkg::pair_id_t    exp_id;
	md_pair_pkg::pair_count_t exp_acc;
	md_pair_pkg::pair_count_t exp_rej;

	int seed;
	int cycles;
	int errors;
	int test_errors;
	int tests_passed;
	int tests_failed;

	pair_distance_top dut_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.enable         (enable),
		.ref_pos        (ref_pos),
		.nbr_pos        (nbr_pos),
		.out_valid      (out_valid),
		.out_pair       (out_pair),
		.accepted_count (accepted_count),
		.rejected_count (rejected_count)
	);

	// 8 ns clock
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Watchdog on total cycles
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Simulation failed");
		$finish;
	end

	function automatic md_pair_pkg::pos_t make_pos(input int x, input int y, input int z);
		md_pair_pkg::pos_t p;
		p.x = md_pair_pkg::coord_t'(x);
		p.y = md_pair_pkg::coord_t'(y);
		p.z = md_pair_pkg::coord_t'(z);
		return p;
	endfunction

	task automatic note_error();
		errors++;
		test_errors++;
	endtask

	// Expected deltas and r2 straight from the coordinate rules
	task automatic model_pair(input md_pair_pkg::pos_t r, input md_pair_pkg::pos_t n);
		md_pair_pkg::r2_result_t e;
		int dx;
		int dy;
		int dz;
		longint r2;
		dx = int'(n.x) - int'(r.x);
		dy = int'(n.y) - int'(r.y);
		dz = int'(n.z) - int'(r.z);
		r2 = longint'(dx) * dx + longint'(dy) * dy + longint'(dz) * dz;
		e.id      = exp_id;
		e.disp.dx = md_pair_pkg::delta_t'(dx);
		e.disp.dy = md_pair_pkg::delta_t'(dy);
		e.disp.dz = md_pair_pkg::delta_t'(dz);
		e.r2      = md_pair_pkg::r2_t'(r2);
		exp_id++;
		// Cutoff 144.0 is 144 * 2**16 raw
		if (r2 < longint'(144) * 65536) begin
			expected_q.push_back(e);
			exp_acc++;
		end else begin
			exp_rej++;
		end
	endtask

	task automatic send_pair(input md_pair_pkg::pos_t r, input md_pair_pkg::pos_t n);
		@(posedge clk);
		enable  <= 1'b1;
		ref_pos <= r;
		nbr_pos <= n;
		model_pair(r, n);
	endtask

	// Idle cycle with junk on the position ports
	task automatic idle_cycle();
		@(posedge clk);
		enable  <= 1'b0;
		ref_pos <= make_pos($random(seed), $random(seed), $random(seed));
		nbr_pos <= make_pos($random(seed), $random(seed), $random(seed));
	endtask

	// Random pair with the neighbor within 8.0 per axis
	task automatic send_random_pair();
		md_pair_pkg::pos_t r;
		md_pair_pkg::pos_t n;
		r = make_pos($random(seed) % 25600, $random(seed) % 25600, $random(seed) % 25600);
		n = make_pos(int'(r.x) + $random(seed) % 2049, int'(r.y) + $random(seed) % 2049,
			int'(r.z) + $random(seed) % 2049);
		send_pair(r, n);
	endtask

	// Drain the pipeline then close the test
	task automatic finish_test(input string name);
		repeat (DRAIN_CYCLES) idle_cycle();
		@(negedge clk);
		assert (expected_q.size() == 0) else begin
			$display("%0d expected outputs never appeared in %s", expected_q.size(), name);
			expected_q.delete();
			note_error();
		end
		assert (accepted_count == exp_acc && rejected_count == exp_rej) else begin
			$display("error at %0t ns: counters %0d/%0d, expected %0d/%0d", $time,
				accepted_count, rejected_count, exp_acc, exp_rej);
			note_error();
		end
		if (test_errors == 0) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d problems", name, test_errors);
		end
		test_errors = 0;
	endtask

	// Output monitor against the model queue
	always @(negedge clk) begin
		if (rst_n && out_valid) begin
			if (expected_q.size() == 0) begin
				$display("unexpected output at %0t ns with id %0d", $time, out_pair.id);
				note_error();
			end else begin
				assert (out_pair == expected_q[0]) else begin
					$display("error at %0t ns: id %0d r2 %0h d %0d %0d %0d, expected id %0d r2 %0h",
						$time, out_pair.id, out_pair.r2, out_pair.disp.dx, out_pair.disp.dy,
						out_pair.disp.dz, expected_q[0].id, expected_q[0].r2);
					note_error();
				end
				void'(expected_q.pop_front());
			end
		end
	end

	initial begin
		seed = 32'h5b2944d7;
		errors = 0;
		test_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		exp_id = '0;
		exp_acc = '0;
		exp_rej = '0;
		rst_n = 1'b0;
		enable = 1'b0;
		ref_pos = '0;
		nbr_pos = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		// Quiet outputs until the first enable
		repeat (RESET_TEST_LEN) begin
			idle_cycle();
			@(negedge clk);
			assert (!out_valid && accepted_count == 0 && rejected_count == 0) else begin
				$display("error at %0t ns: output active before any enable", $time);
				note_error();
			end
		end
		finish_test("reset");

		// Classic pairs giving 84.0 and 3.0
		send_pair(make_pos(0, 0, 0), make_pos(2 * ONE, 4 * ONE, 8 * ONE));
		send_pair(make_pos(2 * ONE, 4 * ONE, 8 * ONE), make_pos(0, 0, 0));
		send_pair(make_pos(ONE, ONE, ONE), make_pos(2 * ONE, 2 * ONE, 2 * ONE));
		send_pair(make_pos(2 * ONE, 2 * ONE, 2 * ONE), make_pos(ONE, ONE, ONE));
		finish_test("directed");

		repeat (BURST_LEN) send_random_pair();
		finish_test("back_to_back");

		// Exactly 144.0 is out and one LSB less is in
		send_pair(make_pos(0, 0, 0), make_pos(12 * ONE, 0, 0));
		send_pair(make_pos(0, 0, 0), make_pos(12 * ONE - 1, 0, 0));
		send_pair(make_pos(ONE, 13 * ONE, 0), make_pos(ONE, ONE, 0));
		send_pair(make_pos(0, 0, -ONE), make_pos(0, 0, 11 * ONE - 1));
		finish_test("cutoff_boundary");

		repeat (GAPPED_LEN) begin
			if ($random(seed) & 1) begin
				send_random_pair();
			end else begin
				idle_cycle();
			end
		end
		finish_test("gapped");

		$display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
		if (errors == 0 && tests_failed == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
source/md_pair_pkg.sv
source/pair_sampler.sv
source/r2_compute.sv
source/cutoff_filter.sv
source/pair_distance_top.sv
testbench/pair_distance_properties.sv
testbench/pair_distance_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the pair distance simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/pair_distance_sim

verilator --binary --timing --assert -f vlog.f --top-module pair_distance_tb \
	-Mdir obj_dir -o pair_distance_sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
	echo "no pass line found in $LOG"
	exit 1
fi
exit 0
